/* hw/cache_pkg.sv */
package cache_pkg;

        ////////////////////////////////////////
        // widths
        ////////////////////////////////////////

        localparam int WORD_W      = 32;
        localparam int LINE_WORDS  = 4;
        localparam int OFFSET_BITS = 2;        // log2 of LINE_WORDS
        localparam int ADDR_W      = 32;       // word address, not byte

        ////////////////////////////////////////
        // data and address types
        ////////////////////////////////////////

        typedef logic [WORD_W-1:0]            word_t;
        typedef logic [WORD_W*LINE_WORDS-1:0] line_t;     // word 0 in the low bits
        typedef logic [ADDR_W-1:0]            addr_t;
        typedef logic [OFFSET_BITS-1:0]       offset_t;

        ////////////////////////////////////////
        // controller states
        ////////////////////////////////////////

        // miss path runs EVICT only when the victim is dirty
        typedef enum logic [2:0]
        {
                IDLE,
                LOOKUP,
                EVICT,
                EVICT_WAIT,
                REFILL,
                REFILL_WAIT
        } ctrl_state_t;

endpackage

/* hw/cache_array_if.sv */
`timescale 1ns/1ps

interface cache_array_if
        #(parameter int SET_BITS = 1);

        import cache_pkg::*;

        localparam int TAG_W = ADDR_W - SET_BITS - OFFSET_BITS;

        // request side, from the controller
        logic [SET_BITS-1:0] index;
        logic [TAG_W-1:0]    tag;
        offset_t             offset;
        logic                touch;            // hit way becomes MRU
        logic                wr_word;          // word write into hit way
        word_t               wdata;
        logic                fill;             // line write into victim way
        line_t               fill_line;

        // tag store results
        logic                hit;
        logic                hit_way;
        logic                victim_way;
        logic                victim_dirty;
        logic [TAG_W-1:0]    victim_tag;

        // data store results
        word_t               rd_word;
        line_t               victim_line;

        modport ctrl (output index, tag, offset, touch, wr_word, wdata, fill, fill_line,
                      input  hit, victim_dirty, victim_tag, rd_word, victim_line);

        modport tags (input  index, tag, touch, wr_word, fill,
                      output hit, hit_way, victim_way, victim_dirty, victim_tag);

        modport data (input  index, offset, wr_word, wdata, fill, fill_line,
                             hit_way, victim_way,
                      output rd_word, victim_line);

endinterface

/* hw/cache_tag_store.sv */
`timescale 1ns/1ps

module cache_tag_store
        #(parameter int SET_BITS = 1)
        (
        input  logic          clk,
        input  logic          reset,
        cache_array_if.tags   arr
        );

        import cache_pkg::*;

        localparam int NUM_SETS = 1 << SET_BITS;
        localparam int TAG_W    = ADDR_W - SET_BITS - OFFSET_BITS;

        logic [TAG_W-1:0]          tag_q [NUM_SETS][2];
        logic [NUM_SETS-1:0][1:0]  valid_q;
        logic [NUM_SETS-1:0][1:0]  dirty_q;
        logic [NUM_SETS-1:0][1:0]  mru_q;      // set for the most recently used way

        logic [1:0]                way_hit;
        logic                      victim;

        ////////////////////////////////////////
        // lookup
        ////////////////////////////////////////

        always_comb
        begin
                for (int w = 0; w < 2; w++)
                begin
                        way_hit[w] = valid_q[arr.index][w] && (tag_q[arr.index][w] == arr.tag);
                end
        end

        // an empty way wins, otherwise the way that is not MRU
        always_comb
        begin
                if (!valid_q[arr.index][0])
                begin
                        victim = 1'b0;
                end
                else if (!valid_q[arr.index][1])
                begin
                        victim = 1'b1;
                end
                else
                begin
                        victim = mru_q[arr.index][0];
                end
        end

        assign arr.hit          = |way_hit;
        assign arr.hit_way      = way_hit[1];
        assign arr.victim_way   = victim;
        assign arr.victim_dirty = valid_q[arr.index][victim] && dirty_q[arr.index][victim];
        assign arr.victim_tag   = tag_q[arr.index][victim];

        ////////////////////////////////////////
        // state bits
        ////////////////////////////////////////

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        valid_q <= '0;
                        dirty_q <= '0;
                        mru_q   <= '0;
                end
                else
                begin
                        if (arr.touch)
                        begin
                                mru_q[arr.index][arr.hit_way]  <= 1'b1;
                                mru_q[arr.index][~arr.hit_way] <= 1'b0;
                        end
                        if (arr.wr_word)
                        begin
                                dirty_q[arr.index][arr.hit_way] <= 1'b1;
                        end
                        if (arr.fill)
                        begin
                                valid_q[arr.index][victim] <= 1'b1;
                                dirty_q[arr.index][victim] <= 1'b0;     // fresh from memory
                                mru_q[arr.index][victim]   <= 1'b1;
                                mru_q[arr.index][~victim]  <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk)
        begin
                if (arr.fill)
                begin
                        tag_q[arr.index][victim] <= arr.tag;
                end
        end

        // a line is only ever filled on a miss, so one copy per set
        a_single_hit: assert property (@(posedge clk) disable iff (reset) !(&way_hit));

endmodule

/* hw/cache_data_store.sv */
`timescale 1ns/1ps

module cache_data_store
        #(parameter int SET_BITS = 1)
        (
        input  logic          clk,
        input  logic          reset,
        cache_array_if.data   arr
        );

        import cache_pkg::*;

        localparam int NUM_SETS = 1 << SET_BITS;

        line_t lines_q [NUM_SETS][2];

        ////////////////////////////////////////
        // read side
        ////////////////////////////////////////

        line_t hit_line;

        assign hit_line        = lines_q[arr.index][arr.hit_way];
        assign arr.rd_word     = hit_line[arr.offset*WORD_W +: WORD_W];
        assign arr.victim_line = lines_q[arr.index][arr.victim_way];     // for write-back

        ////////////////////////////////////////
        // write side
        ////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (arr.wr_word)
                begin
                        // only the addressed word of the hit way changes
                        lines_q[arr.index][arr.hit_way][arr.offset*WORD_W +: WORD_W] <= arr.wdata;
                end
                else if (arr.fill)
                begin
                        lines_q[arr.index][arr.victim_way] <= arr.fill_line;
                end
        end

        // fill ends a miss, word writes happen only on a hit
        a_no_write_fill: assert property (@(posedge clk) disable iff (reset)
                !(arr.wr_word && arr.fill));

endmodule

/* hw/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl
        (
        input  logic              clk,
        input  logic              reset,

        input  logic              read_cpu,
        input  logic              write_cpu,
        input  cache_pkg::addr_t  cpu_addr,
        input  cache_pkg::word_t  cpu_wdata,
        output cache_pkg::word_t  cpu_rdata,
        output logic              cpu_rvalid,
        output logic              stall_pc,

        input  logic              ready_mem,
        input  cache_pkg::line_t  mem_rdata,
        output cache_pkg::line_t  mem_wdata,
        output cache_pkg::addr_t  mem_addr,
        output logic              read_mem,
        output logic              write_mem,

        cache_array_if.ctrl       arr
        );

        import cache_pkg::*;

        ctrl_state_t state;
        addr_t       addr_q;           // latched request
        word_t       wdata_q;
        logic        req_write;
        logic        settle_q;         // first cycle after a memory strobe

        addr_t       victim_addr;
        addr_t       refill_addr;

        ////////////////////////////////////////
        // array requests
        ////////////////////////////////////////

        assign {arr.tag, arr.index, arr.offset} = addr_q;
        assign arr.wdata     = wdata_q;
        assign arr.fill_line = mem_rdata;

        assign arr.touch   = (state == LOOKUP) && arr.hit;
        assign arr.wr_word = (state == LOOKUP) && arr.hit && req_write;
        assign arr.fill    = (state == REFILL_WAIT) && !settle_q && ready_mem;

        // line addresses with offset bits zero
        assign victim_addr = {arr.victim_tag, arr.index, {OFFSET_BITS{1'b0}}};
        assign refill_addr = {addr_q[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

        ////////////////////////////////////////
        // strobes and stall
        ////////////////////////////////////////

        assign write_mem = (state == EVICT) && ready_mem;
        assign read_mem  = (state == REFILL) && ready_mem;
        assign stall_pc  = (state != IDLE);

        ////////////////////////////////////////
        // FSM
        ////////////////////////////////////////

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        state      <= IDLE;
                        addr_q     <= '0;
                        req_write  <= 1'b0;
                        settle_q   <= 1'b0;
                        cpu_rvalid <= 1'b0;
                        mem_addr   <= '0;
                end
                else
                begin
                        cpu_rvalid <= 1'b0;
                        settle_q   <= 1'b0;
                        case (state)
                                IDLE:
                                begin
                                        if (read_cpu || write_cpu)
                                        begin
                                                addr_q    <= cpu_addr;
                                                req_write <= write_cpu;
                                                state     <= LOOKUP;
                                        end
                                end
                                LOOKUP:
                                begin
                                        if (arr.hit)
                                        begin
                                                cpu_rvalid <= !req_write;
                                                state      <= IDLE;
                                        end
                                        else if (arr.victim_dirty)
                                        begin
                                                mem_addr <= victim_addr;
                                                state    <= EVICT;
                                        end
                                        else
                                        begin
                                                mem_addr <= refill_addr;
                                                state    <= REFILL;
                                        end
                                end
                                EVICT:
                                begin
                                        if (ready_mem)         // write_mem goes out this cycle
                                        begin
                                                settle_q <= 1'b1;
                                                state    <= EVICT_WAIT;
                                        end
                                end
                                EVICT_WAIT:
                                begin
                                        if (!settle_q && ready_mem)
                                        begin
                                                mem_addr <= refill_addr;
                                                state    <= REFILL;
                                        end
                                end
                                REFILL:
                                begin
                                        if (ready_mem)
                                        begin
                                                settle_q <= 1'b1;
                                                state    <= REFILL_WAIT;
                                        end
                                end
                                REFILL_WAIT:
                                begin
                                        if (!settle_q && ready_mem)
                                        begin
                                                state <= LOOKUP;       // replay as a hit
                                        end
                                end
                                default:
                                begin
                                        state <= IDLE;
                                end
                        endcase
                end
        end

        // data registers
        always_ff @(posedge clk)
        begin
                if (state == IDLE && (read_cpu || write_cpu))
                begin
                        wdata_q <= cpu_wdata;
                end
                if (state == LOOKUP && arr.hit)
                begin
                        cpu_rdata <= arr.rd_word;
                end
                if (state == LOOKUP && !arr.hit && arr.victim_dirty)
                begin
                        mem_wdata <= arr.victim_line;  // held until the write strobe
                end
        end

        ////////////////////////////////////////
        // memory port checks
        ////////////////////////////////////////

        a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
                !(read_mem && write_mem));

        // one-cycle strobes only while ready_mem is high
        a_strobe_ready: assert property (@(posedge clk) disable iff (reset)
                (read_mem || write_mem) |-> ready_mem ##1 !(read_mem || write_mem));

endmodule

/* hw/cache_top.sv */
`timescale 1ns/1ps

module cache_top
        #(parameter int SET_BITS = 1)
        (
        input  logic              clk,
        input  logic              reset,

        // CPU port
        input  logic              read_cpu,
        input  logic              write_cpu,
        input  cache_pkg::addr_t  cpu_addr,
        input  cache_pkg::word_t  cpu_wdata,
        output cache_pkg::word_t  cpu_rdata,
        output logic              cpu_rvalid,
        output logic              stall_pc,

        // memory port, whole lines only
        input  logic              ready_mem,
        input  cache_pkg::line_t  mem_rdata,
        output cache_pkg::line_t  mem_wdata,
        output cache_pkg::addr_t  mem_addr,
        output logic              read_mem,
        output logic              write_mem
        );

        cache_array_if #(.SET_BITS(SET_BITS)) arr ();

        cache_ctrl u_ctrl
        (
                .clk        (clk),
                .reset      (reset),
                .read_cpu   (read_cpu),
                .write_cpu  (write_cpu),
                .cpu_addr   (cpu_addr),
                .cpu_wdata  (cpu_wdata),
                .cpu_rdata  (cpu_rdata),
                .cpu_rvalid (cpu_rvalid),
                .stall_pc   (stall_pc),
                .ready_mem  (ready_mem),
                .mem_rdata  (mem_rdata),
                .mem_wdata  (mem_wdata),
                .mem_addr   (mem_addr),
                .read_mem   (read_mem),
                .write_mem  (write_mem),
                .arr        (arr.ctrl)
        );

        cache_tag_store #(.SET_BITS(SET_BITS)) u_tags
        (
                .clk   (clk),
                .reset (reset),
                .arr   (arr.tags)
        );

        cache_data_store #(.SET_BITS(SET_BITS)) u_data
        (
                .clk   (clk),
                .reset (reset),
                .arr   (arr.data)
        );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
        #(parameter int PERIOD_NS    = 20,
          parameter int RESET_CYCLES = 8)
        (
        output logic clk,
        output logic reset
        );

        initial
        begin
                clk = 1'b0;
                forever #(PERIOD_NS / 2) clk = ~clk;
        end

        // released on a rising edge, flops still see reset there
        initial
        begin
                reset = 1'b1;
                repeat (RESET_CYCLES) @(posedge clk);
                reset <= 1'b0;
        end

endmodule

/* sim/cache_tb_mem.sv */
`timescale 1ns/1ps

module cache_tb_mem
        #(parameter int MEM_LATENCY = 5,
          parameter int NUM_LINES   = 64)
        (
        input  logic              clk,
        input  logic              reset,
        input  logic              read_mem,
        input  logic              write_mem,
        input  cache_pkg::addr_t  mem_addr,
        input  cache_pkg::line_t  mem_wdata,
        output cache_pkg::line_t  mem_rdata,
        output logic              ready_mem
        );

        import cache_pkg::*;

        line_t blocks [NUM_LINES];
        int    busy_cnt;
        int    rd_line;
        logic  read_busy;
        int    line_sel;

        // scramble of the whole word address
        function automatic word_t initial_word(input addr_t addr);
                return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
        endfunction

        assign line_sel = (mem_addr >> OFFSET_BITS) % NUM_LINES;

        initial
        begin
                for (int l = 0; l < NUM_LINES; l++)
                begin
                        for (int w = 0; w < LINE_WORDS; w++)
                        begin
                                blocks[l][w*WORD_W +: WORD_W] = initial_word(addr_t'(l*LINE_WORDS + w));
                        end
                end
        end

        always @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        ready_mem <= 1'b1;
                        busy_cnt  <= 0;
                        rd_line   <= 0;
                        read_busy <= 1'b0;
                        mem_rdata <= '0;
                end
                else if (ready_mem && (read_mem || write_mem))
                begin
                        ready_mem <= 1'b0;             // busy from the next cycle
                        busy_cnt  <= MEM_LATENCY - 1;
                        read_busy <= read_mem;
                        rd_line   <= line_sel;
                        if (write_mem)
                        begin
                                blocks[line_sel] <= mem_wdata;
                        end
                end
                else if (!ready_mem)
                begin
                        if (busy_cnt == 0)
                        begin
                                ready_mem <= 1'b1;
                                if (read_busy)
                                begin
                                        mem_rdata <= blocks[rd_line];   // valid with ready
                                end
                        end
                        else
                        begin
                                busy_cnt <= busy_cnt - 1;
                        end
                end
        end

endmodule

/* sim/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

        import cache_pkg::*;

        localparam int SET_BITS     = 1;
        localparam int MEM_LATENCY  = 5;
        localparam int CLK_PERIOD   = 20;
        localparam int DIRECTED_OPS = 12;
        localparam int NUM_RANDOM   = 300;
        localparam int OP_CYCLES    = 2*(MEM_LATENCY+4) + 4;      // two transfers plus slack
        localparam longint TIMEOUT_NS = longint'(DIRECTED_OPS + NUM_RANDOM + 8)
                                        * OP_CYCLES * CLK_PERIOD;

        logic  clk;
        logic  reset;
        logic  read_cpu;
        logic  write_cpu;
        addr_t cpu_addr;
        word_t cpu_wdata;
        word_t cpu_rdata;
        logic  cpu_rvalid;
        logic  stall_pc;
        logic  ready_mem;
        line_t mem_rdata;
        line_t mem_wdata;
        addr_t mem_addr;
        logic  read_mem;
        logic  write_mem;

        word_t       shadow [addr_t];   // words written so far
        word_t       read_exp;
        logic        read_pending;
        int          read_strobes;
        int          write_strobes;
        addr_t       last_wb_addr;
        time         req_time;          // edge where the last request was driven
        time         rvalid_time;       // negedge where cpu_rvalid was last seen
        logic [31:0] rng;

        tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(8)) u_clock
        (
                .clk   (clk),
                .reset (reset)
        );

        cache_tb_mem #(.MEM_LATENCY(MEM_LATENCY), .NUM_LINES(64)) u_mem
        (
                .clk       (clk),
                .reset     (reset),
                .read_mem  (read_mem),
                .write_mem (write_mem),
                .mem_addr  (mem_addr),
                .mem_wdata (mem_wdata),
                .mem_rdata (mem_rdata),
                .ready_mem (ready_mem)
        );

        cache_top #(.SET_BITS(SET_BITS)) DUT
        (
                .clk        (clk),
                .reset      (reset),
                .read_cpu   (read_cpu),
                .write_cpu  (write_cpu),
                .cpu_addr   (cpu_addr),
                .cpu_wdata  (cpu_wdata),
                .cpu_rdata  (cpu_rdata),
                .cpu_rvalid (cpu_rvalid),
                .stall_pc   (stall_pc),
                .ready_mem  (ready_mem),
                .mem_rdata  (mem_rdata),
                .mem_wdata  (mem_wdata),
                .mem_addr   (mem_addr),
                .read_mem   (read_mem),
                .write_mem  (write_mem)
        );

        ////////////////////////////////////////
        // reference model
        ////////////////////////////////////////

        function automatic word_t initial_word(input addr_t addr);
                return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
        endfunction

        function automatic word_t exp_read(input addr_t addr);
                if (shadow.exists(addr))
                begin
                        return shadow[addr];
                end
                return initial_word(addr);
        endfunction

        function automatic line_t expected_line(input addr_t base);
                line_t l;
                for (int w = 0; w < LINE_WORDS; w++)
                begin
                        l[w*WORD_W +: WORD_W] = exp_read(base + addr_t'(w));
                end
                return l;
        endfunction

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        ////////////////////////////////////////
        // checks
        ////////////////////////////////////////

        task automatic abort_run();
                $display("Test failed");
                $fatal(1, "simulation stopped at first error");
        endtask

        task automatic expect_true(input logic cond, input string what);
                if (!cond)
                begin
                        $display("ERROR at %0t ns: %s", $time, what);
                        abort_run();
                end
        endtask

        task automatic check_word(input string name, input word_t got, input word_t exp);
                if (got !== exp)
                begin
                        $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_addr(input string name, input addr_t got, input addr_t exp);
                if (got !== exp)
                begin
                        $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_line(input string name, input line_t got, input line_t exp);
                if (got !== exp)
                begin
                        $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
                        abort_run();
                end
        endtask

        // DUT outputs sampled mid-cycle where they are settled
        always @(negedge clk)
        begin
                if (!reset)
                begin
                        if (read_mem)
                        begin
                                read_strobes++;
                        end
                        if (write_mem)
                        begin
                                write_strobes++;
                                last_wb_addr = mem_addr;
                        end
                        if (cpu_rvalid)
                        begin
                                expect_true(read_pending, "cpu_rvalid with no read pending");
                                check_word("cpu_rdata", cpu_rdata, read_exp);
                                read_pending = 1'b0;
                                rvalid_time  = $time;
                        end
                end
        end

        ////////////////////////////////////////
        // stimulus
        ////////////////////////////////////////

        // one access and its count of stalled cycles
        task automatic run_access(input logic is_write, input addr_t addr, input word_t data,
                                  output int stall_cycles);
                @(posedge clk);
                read_cpu  <= !is_write;
                write_cpu <= is_write;
                cpu_addr  <= addr;
                cpu_wdata <= data;
                req_time  = $time;
                if (is_write)
                begin
                        shadow[addr] = data;
                end
                else
                begin
                        read_exp     = exp_read(addr);
                        read_pending = 1'b1;
                end
                @(posedge clk);            // accepted here
                read_cpu  <= 1'b0;
                write_cpu <= 1'b0;
                stall_cycles = 0;
                @(negedge clk);
                while (stall_pc)
                begin
                        stall_cycles++;
                        @(negedge clk);
                end
                @(posedge clk);
                expect_true(!read_pending, "read finished without cpu_rvalid");
        endtask

        initial
        begin
                int    lat;
                int    rs0;
                int    ws0;
                addr_t addr;

                read_cpu      = 1'b0;
                write_cpu     = 1'b0;
                cpu_addr      = '0;
                cpu_wdata     = '0;
                read_pending  = 1'b0;
                read_strobes  = 0;
                write_strobes = 0;
                last_wb_addr  = '0;
                req_time      = 0;
                rvalid_time   = 0;
                rng           = 32'h73d5;

                @(negedge reset);
                @(negedge clk);
                expect_true(!stall_pc && !cpu_rvalid && !read_mem && !write_mem,
                            "outputs not low after reset");

                // read miss, then hit in the same line
                run_access(1'b0, 32'h21, '0, lat);
                expect_true(read_strobes == 1 && write_strobes == 0, "read miss did not refill once");
                rs0 = read_strobes;
                run_access(1'b0, 32'h22, '0, lat);
                expect_true(lat == 1, "read hit did not stall exactly one cycle");
                expect_true(rvalid_time == req_time + 2*CLK_PERIOD + CLK_PERIOD/2,
                            "read hit data not valid two edges after the request");
                expect_true(read_strobes == rs0, "read hit went to memory");

                // write hit then read back
                run_access(1'b1, 32'h23, 32'hcafe_0123, lat);
                run_access(1'b0, 32'h23, '0, lat);
                expect_true(write_strobes == 0, "write hit wrote to memory");

                // three lines in set 1 so the dirty LRU one goes back to memory
                ws0 = write_strobes;
                run_access(1'b1, 32'h05, 32'hbeef_0005, lat);
                run_access(1'b0, 32'h0d, '0, lat);
                run_access(1'b0, 32'h16, '0, lat);
                expect_true(write_strobes == ws0 + 1, "dirty victim not written back once");
                check_addr("mem_addr", last_wb_addr, 32'h04);
                check_line("u_mem.blocks[1]", u_mem.blocks[1], expected_line(32'h04));

                // write miss allocates and neighbours keep their pattern
                rs0 = read_strobes;
                ws0 = write_strobes;
                run_access(1'b1, 32'h31, 32'h1234_5678, lat);
                expect_true(read_strobes == rs0 + 1 && write_strobes == ws0,
                            "write miss did not allocate with one refill");
                run_access(1'b0, 32'h30, '0, lat);
                run_access(1'b0, 32'h32, '0, lat);
                run_access(1'b0, 32'h33, '0, lat);
                run_access(1'b0, 32'h31, '0, lat);

                // random mix over 64 lines
                for (int i = 0; i < NUM_RANDOM; i++)
                begin
                        rng  = xorshift32(rng);
                        addr = addr_t'(rng[7:0]);
                        rng  = xorshift32(rng);
                        run_access(rng[31], addr, rng, lat);
                end

                $display("Test completed successfully");
                $finish;
        end

        initial
        begin
                #(TIMEOUT_NS);
                $display("ERROR at %0t ns: watchdog expired, an access never finished", $time);
                abort_run();
        end

endmodule

/* files.f */
hw/cache_pkg.sv
hw/cache_array_if.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
sim/tb_clock.sv
sim/cache_tb_mem.sv
sim/cache_tb.sv
